// ==== sources.f ====
+incdir+design
design/chiplet_pkg.sv
design/msg_table.sv
design/pkt_mem.sv
design/crc32_word.sv
design/tx_fsm.sv
design/chiplet_tx_top.sv
sim/chiplet_tx_tb.sv

// ==== Bender.yml ====
package:
  name: chiplet_tx

sources:
  - include_dirs:
      - design
    files:
      - design/chiplet_pkg.sv
      - design/msg_table.sv
      - design/pkt_mem.sv
      - design/crc32_word.sv
      - design/tx_fsm.sv
      - design/chiplet_tx_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/chiplet_tx_tb.sv

// ==== sim/chiplet_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chiplet_config.svh"

module chiplet_tx_tb
    import chiplet_pkg::*;
();
    localparam int TIMEOUT = 200;     // Cycles per wait

    logic      clk;
    logic      n_rst;
    logic      cfg_req;
    cfg_addr_t cfg_addr;
    word_t     cfg_wdata;
    logic      cfg_ack;
    logic      flit_req;
    node_id_t  flit_node;
    pkt_id_t   flit_id;
    word_t     flit_data;
    logic      flit_ack;
    logic      busy;

    integer    seed = 32'h6770;
    word_t     tb_mem [`CHIP_MEM_DEPTH];    // Reference image of packet memory
    mem_addr_t tb_start [`CHIP_NUM_MSGS];
    node_id_t  tb_node;
    logic [37:0] exp_q [$];                 // {node, slot, data} per flit
    int        exp_cnt;

    chiplet_tx_top chiplet_tx_top_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .cfg_req   (cfg_req),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .flit_ack  (flit_ack),
        .cfg_ack   (cfg_ack),
        .flit_req  (flit_req),
        .flit_node (flit_node),
        .flit_id   (flit_id),
        .flit_data (flit_data),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_value_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // Poly 04C11DB7, MSB first, no reflection, no final XOR
    task automatic crc_over(input word_t words[$], output word_t crc);
        logic fb;
        crc = `CHIP_CRC_INIT;
        foreach (words[w]) begin
            for (int b = 31; b >= 0; b--) begin
                fb  = crc[31] ^ words[w][b];
                crc = {crc[30:0], 1'b0};
                if (fb) begin
                    crc = crc ^ 32'h04C1_1DB7;
                end
            end
        end
    endtask

    task automatic host_write(input cfg_addr_t addr, input word_t data);
        int n;
        if (!addr[8]) begin
            tb_mem[addr[5:0]] = data;
        end else if (addr[7:0] < `CHIP_NUM_MSGS) begin
            tb_start[addr[1:0]] = data[5:0];
        end else if (addr[7:0] == 8'd4) begin
            tb_node = data[3:0];
        end
        @(posedge clk);
        cfg_req   <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        n = 0;
        @(negedge clk);
        while (!cfg_ack) begin
            if (n == TIMEOUT) report_failure("The host write never got cfg_ack.");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        cfg_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (cfg_ack) begin
            if (n == TIMEOUT) report_failure("cfg_ack never fell after cfg_req dropped.");
            n++;
            @(negedge clk);
        end
    endtask

    // Header with random upper bits, then len random payload words
    task automatic load_packet(input int slot, input mem_addr_t base, input pkt_len_t len);
        word_t     w;
        mem_addr_t a;
        a = base;
        w = ($random(seed) & 32'hFFFF_FFC0) | 32'(len);
        host_write({3'b000, a}, w);
        for (int i = 0; i < len; i++) begin
            a = a + 1'b1;                   // Wraps past 63
            host_write({3'b000, a}, $random(seed));
        end
        host_write(9'h100 + 9'(slot), 32'(base));
    endtask

    task automatic expect_packet(input int slot);
        word_t     words[$];
        mem_addr_t a;
        pkt_len_t  len;
        word_t     crc;
        a   = tb_start[slot];
        len = tb_mem[a][`CHIP_LEN_WIDTH-1:0];
        for (int i = 0; i <= len; i++) begin
            words.push_back(tb_mem[a]);
            a = a + 1'b1;
        end
        crc_over(words, crc);
        foreach (words[i]) begin
            exp_q.push_back({tb_node, pkt_id_t'(slot), words[i]});
        end
        exp_q.push_back({tb_node, pkt_id_t'(slot), crc});
        exp_cnt = exp_q.size();
    endtask

    // Highest slot goes out first
    task automatic trigger(input logic [`CHIP_NUM_MSGS-1:0] mask);
        for (int i = `CHIP_NUM_MSGS - 1; i >= 0; i--) begin
            if (mask[i]) expect_packet(i);
        end
        host_write(9'h105, 32'(mask));
    endtask

    task automatic receive_flit();
        logic [37:0] exp;
        int          n;
        int          delay;
        n = 0;
        @(negedge clk);
        while (!flit_req) begin
            if (n == TIMEOUT) report_failure("No flit arrived while flits were still expected.");
            n++;
            @(negedge clk);
        end
        exp = exp_q[0];
        assert (flit_data == exp[31:0]) else report_value_error(
            $sformatf("flit_data %h, expected %h", flit_data, exp[31:0]));
        assert (flit_id == exp[33:32]) else report_value_error(
            $sformatf("flit_id %0d, expected %0d", flit_id, exp[33:32]));
        assert (flit_node == exp[37:34]) else report_value_error(
            $sformatf("flit_node %h, expected %h", flit_node, exp[37:34]));
        delay = $random(seed) & 3;
        repeat (delay) @(negedge clk);     // Back-pressure
        @(posedge clk);
        flit_ack <= 1'b1;
        n = 0;
        @(negedge clk);
        while (flit_req) begin
            if (n == TIMEOUT) report_failure("flit_req stayed high after flit_ack.");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        flit_ack <= 1'b0;
        void'(exp_q.pop_front());
        exp_cnt = exp_q.size();
    endtask

    task automatic drain();
        int n;
        while (exp_q.size() > 0) begin
            receive_flit();
        end
        n = 0;
        @(negedge clk);
        while (busy) begin
            if (n == TIMEOUT) report_failure("busy stayed high after the last CRC flit.");
            n++;
            @(negedge clk);
        end
    endtask

    a_flit_stable: assert property (@(posedge clk) disable iff (!n_rst)
        (flit_req && !flit_ack) |=> flit_req && $stable(flit_data)
            && $stable(flit_node) && $stable(flit_id))
        else report_failure("A flit changed or was withdrawn before it was acknowledged.");

    a_no_extra_flit: assert property (@(posedge clk) disable iff (!n_rst)
        flit_req |-> (exp_cnt > 0))
        else report_failure("The DUT sent a flit that was not expected.");

    a_cfg_ack_delay: assert property (@(posedge clk) disable iff (!n_rst)
        (cfg_req && !cfg_ack) |=> cfg_ack)
        else report_failure("cfg_ack did not rise one cycle after cfg_req.");

    a_cfg_ack_release: assert property (@(posedge clk) disable iff (!n_rst)
        (!cfg_req && cfg_ack) |=> !cfg_ack)
        else report_failure("cfg_ack stayed high more than one cycle after cfg_req fell.");

    // A packet in flight keeps busy up
    a_busy_flit: assert property (@(posedge clk) disable iff (!n_rst)
        flit_req |-> busy)
        else report_failure("busy was low while a flit was being offered.");

    initial begin
        n_rst     = 1'b0;
        cfg_req   = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        flit_ack  = 1'b0;
        exp_cnt   = 0;
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        assert (!flit_req && !cfg_ack && !busy)
            else report_value_error("outputs not idle after reset");

        host_write(9'h104, 32'hA);
        load_packet(1, 6'd8, 6'd3);
        trigger(4'b0010);
        drain();

        // Two slots in one trigger write
        host_write(9'h104, 32'h5);
        load_packet(3, 6'd20, 6'd5);
        load_packet(0, 6'd40, 6'd2);
        trigger(4'b1001);
        drain();

        load_packet(2, 6'd60, 6'd6);        // Payload runs 61 to 2
        trigger(4'b0100);
        drain();

        repeat (5) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/chiplet_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chiplet_config.svh"

module chiplet_tx_top
    import chiplet_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      n_rst,
    input  wire logic      cfg_req,
    input  wire cfg_addr_t cfg_addr,
    input  wire word_t     cfg_wdata,
    input  wire logic      flit_ack,
    output logic           cfg_ack,
    output logic           flit_req,
    output node_id_t       flit_node,
    output pkt_id_t        flit_id,
    output word_t          flit_data,
    output logic           busy
);
    logic [`CHIP_NUM_MSGS-1:0]      pending;
    mem_addr_t [`CHIP_NUM_MSGS-1:0] start_addr;
    node_id_t                       node_id;
    logic                           take_valid;
    pkt_id_t                        take_id;

    // Memory ports
    logic      mem_we;
    mem_addr_t mem_waddr;
    word_t     mem_wdata;
    mem_addr_t rd_addr;
    word_t     rd_data;

    logic  crc_clear;
    logic  crc_update;
    word_t crc_in;
    word_t crc_value;

    msg_table msg_table_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .cfg_req    (cfg_req),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .take_valid (take_valid),
        .take_id    (take_id),
        .cfg_ack    (cfg_ack),
        .pending    (pending),
        .start_addr (start_addr),
        .node_id    (node_id),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata)
    );

    pkt_mem pkt_mem_i (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    crc32_word crc32_word_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_in     (crc_in),
        .crc_value  (crc_value)
    );

    tx_fsm tx_fsm_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .pending    (pending),
        .start_addr (start_addr),
        .node_id    (node_id),
        .rd_data    (rd_data),
        .crc_value  (crc_value),
        .flit_ack   (flit_ack),
        .take_valid (take_valid),
        .take_id    (take_id),
        .rd_addr    (rd_addr),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_in     (crc_in),
        .flit_req   (flit_req),
        .flit_node  (flit_node),
        .flit_id    (flit_id),
        .flit_data  (flit_data),
        .busy       (busy)
    );

endmodule

`default_nettype wire

// ==== design/tx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chiplet_config.svh"

module tx_fsm
    import chiplet_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         n_rst,
    input  wire logic [`CHIP_NUM_MSGS-1:0]    pending,
    input  wire mem_addr_t [`CHIP_NUM_MSGS-1:0] start_addr,
    input  wire node_id_t                     node_id,
    input  wire word_t                        rd_data,
    input  wire word_t                        crc_value,
    input  wire logic                         flit_ack,
    output logic                              take_valid,
    output pkt_id_t                           take_id,
    output mem_addr_t                         rd_addr,
    output logic                              crc_clear,
    output logic                              crc_update,
    output word_t                             crc_in,
    output logic                              flit_req,
    output node_id_t                          flit_node,
    output pkt_id_t                           flit_id,
    output word_t                             flit_data,
    output logic                              busy
);
    typedef enum logic [2:0] {
        IDLE, FETCH, LOAD, SEND, WAIT_LOW, CRC_SEND, CRC_LOW
    } tx_state_e;

    tx_state_e state, next_state;
    pkt_id_t   pick_id;     // Highest pending slot
    pkt_id_t   slot_r;
    node_id_t  node_r;
    mem_addr_t addr_r;
    word_t     data_r;
    pkt_len_t  len_r;
    pkt_len_t  word_cnt;    // Payload words acked so far
    logic      hdr_r;
    logic      last_word;

    always_comb begin
        pick_id = '0;
        for (int i = 0; i < `CHIP_NUM_MSGS; i++) begin
            if (pending[i]) begin
                pick_id = pkt_id_t'(i);
            end
        end
    end

    assign last_word = !hdr_r && (word_cnt == len_r);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (|pending) next_state = FETCH;
            FETCH:    next_state = LOAD;   // rd_data valid next cycle
            LOAD:     next_state = SEND;
            SEND:     if (flit_ack) next_state = WAIT_LOW;
            WAIT_LOW: if (!flit_ack) next_state = last_word ? CRC_SEND : FETCH;
            CRC_SEND: if (flit_ack) next_state = CRC_LOW;
            CRC_LOW:  if (!flit_ack) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            slot_r   <= '0;
            node_r   <= '0;
            addr_r   <= '0;
            len_r    <= '0;
            word_cnt <= '0;
            hdr_r    <= 1'b0;
        end else begin
            state <= next_state;
            if (take_valid) begin
                slot_r   <= pick_id;
                node_r   <= node_id;
                addr_r   <= start_addr[pick_id];
                len_r    <= '1;             // Real length comes with the header
                word_cnt <= '0;
                hdr_r    <= 1'b1;
            end else if ((state == SEND) && flit_ack) begin
                addr_r <= addr_r + 1'b1;    // Wraps mod memory depth
                hdr_r  <= 1'b0;
                if (hdr_r) begin
                    len_r <= data_r[`CHIP_LEN_WIDTH-1:0];
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            data_r <= rd_data;
        end else if ((state == WAIT_LOW) && !flit_ack && last_word) begin
            data_r <= crc_value;            // Final flit
        end
    end

    assign take_valid = (state == IDLE) && (|pending);
    assign take_id    = pick_id;
    assign crc_clear  = take_valid;
    assign crc_update = (state == SEND) && flit_ack;
    assign crc_in     = data_r;
    assign rd_addr    = addr_r;
    assign flit_req   = (state == SEND) || (state == CRC_SEND);
    assign flit_node  = node_r;
    assign flit_id    = slot_r;
    assign flit_data  = data_r;
    assign busy       = (state != IDLE);

    a_flit_stable: assert property (@(posedge clk) disable iff (!n_rst)
        (flit_req && !flit_ack) |=> flit_req && $stable(flit_data)
            && $stable(flit_node) && $stable(flit_id))
        else $error("Flit changed while waiting for ack");

    // Header in memory must carry a nonzero length
    a_len_nonzero: assert property (@(posedge clk) disable iff (!n_rst)
        (state != IDLE) |-> (len_r != '0))
        else $error("Packet length is zero");

endmodule

`default_nettype wire

// ==== design/crc32_word.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chiplet_config.svh"

module crc32_word
    import chiplet_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  n_rst,
    input  wire logic  crc_clear,
    input  wire logic  crc_update,
    input  wire word_t crc_in,
    output word_t      crc_value
);
    localparam word_t POLY = 32'h04C1_1DB7;

    word_t crc_next;

    // MSB first, one shift per data bit
    function automatic word_t crc_fold(word_t crc, word_t data);
        word_t c;
        c = crc;
        for (int i = 31; i >= 0; i--) begin
            if (c[31] ^ data[i]) begin
                c = (c << 1) ^ POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_fold(crc_value, crc_in);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_value <= `CHIP_CRC_INIT;
        end else if (crc_clear) begin
            crc_value <= `CHIP_CRC_INIT;  // New packet
        end else if (crc_update) begin
            crc_value <= crc_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/pkt_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chiplet_config.svh"

module pkt_mem
    import chiplet_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      mem_we,
    input  wire mem_addr_t mem_waddr,
    input  wire word_t     mem_wdata,
    input  wire mem_addr_t rd_addr,
    output word_t          rd_data
);
    word_t mem [`CHIP_MEM_DEPTH];

    // Host side write
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/msg_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chiplet_config.svh"

module msg_table
    import chiplet_pkg::*;
(
    input  wire logic                             clk,
    input  wire logic                             n_rst,
    input  wire logic                             cfg_req,
    input  wire cfg_addr_t                        cfg_addr,
    input  wire word_t                            cfg_wdata,
    input  wire logic                             take_valid,
    input  wire pkt_id_t                          take_id,
    output logic                                  cfg_ack,
    output logic [`CHIP_NUM_MSGS-1:0]             pending,
    output mem_addr_t [`CHIP_NUM_MSGS-1:0]        start_addr,
    output node_id_t                              node_id,
    output logic                                  mem_we,
    output mem_addr_t                             mem_waddr,
    output word_t                                 mem_wdata
);
    localparam logic [7:0] NODE_REG = 8'd4;
    localparam logic [7:0] TRIG_REG = 8'd5;

    logic                      wr_en;   // One cycle per host transfer
    logic                      reg_wr;
    logic [`CHIP_NUM_MSGS-1:0] next_pending;

    assign wr_en  = cfg_req && !cfg_ack;
    assign reg_wr = wr_en && cfg_addr[8];

    // Trigger ones land after the take so a new trigger is not lost
    always_comb begin
        next_pending = pending;
        if (take_valid) begin
            next_pending[take_id] = 1'b0;
        end
        if (reg_wr && (cfg_addr[7:0] == TRIG_REG)) begin
            next_pending = next_pending | cfg_wdata[`CHIP_NUM_MSGS-1:0];
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            cfg_ack    <= 1'b0;
            pending    <= '0;
            start_addr <= '0;
            node_id    <= '0;
            mem_we     <= 1'b0;
        end else begin
            pending <= next_pending;
            mem_we  <= wr_en && !cfg_addr[8];

            if (wr_en) begin
                cfg_ack <= 1'b1;
            end else if (!cfg_req) begin
                cfg_ack <= 1'b0;        // Release once req is seen low
            end

            if (reg_wr && (cfg_addr[7:0] == NODE_REG)) begin
                node_id <= cfg_wdata[$bits(node_id_t)-1:0];
            end

            for (int i = 0; i < `CHIP_NUM_MSGS; i++) begin
                if (reg_wr && (cfg_addr[7:0] == 8'(i))) begin
                    start_addr[i] <= cfg_wdata[$bits(mem_addr_t)-1:0];
                end
            end
        end
    end

    // Memory write payload
    always_ff @(posedge clk) begin
        mem_waddr <= cfg_addr[$bits(mem_addr_t)-1:0];
        mem_wdata <= cfg_wdata;
    end

    // A take only ever names a slot that is pending
    a_take_pending: assert property (@(posedge clk) disable iff (!n_rst)
        take_valid |-> pending[take_id])
        else $error("take_valid for a slot that is not pending");

endmodule

`default_nettype wire

// ==== design/chiplet_pkg.sv ====
`default_nettype none

`include "chiplet_config.svh"

package chiplet_pkg;

    // Memory word, flit payload and CRC value
    typedef logic [31:0] word_t;

    typedef logic [$clog2(`CHIP_MEM_DEPTH)-1:0] mem_addr_t;

    // Message slot index
    typedef logic [$clog2(`CHIP_NUM_MSGS)-1:0] pkt_id_t;

    typedef logic [3:0] node_id_t;

    // Payload word count from the header
    typedef logic [`CHIP_LEN_WIDTH-1:0] pkt_len_t;

    // Host write address, bit 8 selects the register block
    typedef logic [8:0] cfg_addr_t;

endpackage

`default_nettype wire

// ==== design/chiplet_config.svh ====
`ifndef CHIPLET_CONFIG_SVH
`define CHIPLET_CONFIG_SVH

// Message slots in the table
`define CHIP_NUM_MSGS 4

// Packet memory words
`define CHIP_MEM_DEPTH 64

// Length field in header bits 5:0
`define CHIP_LEN_WIDTH 6

// CRC-32 start value
`define CHIP_CRC_INIT 32'hFFFF_FFFF

`endif
